//--- sources.f
+incdir+hw
hw/bus_pkg.sv
hw/analog_pkg.sv
hw/sys_bus_if.sv
hw/sys_bus_decoder.sv
hw/housekeeping_regs.sv
hw/analog_io.sv
hw/output_router.sv
hw/rp_top.sv
verif/rp_tb.sv

//--- Bender.yml
package:
  name: rp_fast_path

export_include_dirs:
  - hw

sources:
  - hw/bus_pkg.sv
  - hw/analog_pkg.sv
  - hw/sys_bus_if.sv
  - hw/sys_bus_decoder.sv
  - hw/housekeeping_regs.sv
  - hw/analog_io.sv
  - hw/output_router.sv
  - hw/rp_top.sv
  - target: test
    files:
      - verif/rp_tb.sv

//--- verif/rp_tb.sv
// testbench for the fast analog path top level
// drives inputs 2 units after the rising edge and samples at the same point
// bus model: one access at a time, ack expected exactly one cycle after strobe
// reference model tracks every register and a 3-deep DAC code pipeline
// random stimulus from $urandom, fixed seed
`include "rp_defs.svh"

module rp_tb;

  localparam int RST_CYCLES = 8;
  localparam int HK_ITER    = 40;   // random register accesses
  localparam int UNM_ITER   = 16;   // accesses to empty regions
  localparam int STREAM_LEN = 64;   // sample stream length
  localparam int SETTLE     = 4;    // loopback settle cycles
  localparam int ACK_LIMIT  = 8;
  localparam int BUS_CYC    = 3;    // strobe, ack, idle
  localparam int NREG       = 10;
  localparam int CYCLE_LIMIT = RST_CYCLES + 10 + HK_ITER * 4 * BUS_CYC + UNM_ITER * BUS_CYC
                             + 3 * NREG * BUS_CYC + 10 * BUS_CYC + 2 * STREAM_LEN
                             + STREAM_LEN / 2 + SETTLE + 200;  // plus margin

  logic                  adc_clk;
  logic                  rst_i;
  logic [`RP_ADDR_W-1:0] sys_addr_i;
  logic [`RP_DATA_W-1:0] sys_wdata_i;
  logic [ `RP_SEL_W-1:0] sys_sel_i;
  logic                  sys_wen_i, sys_ren_i;
  logic [`RP_DATA_W-1:0] sys_rdata_o;
  logic                  sys_err_o, sys_ack_o;
  logic [ `RP_SMP_W-1:0] adc_dat_a_i, adc_dat_b_i, dac_dat_a_o, dac_dat_b_o;
  logic [ `RP_EXP_W-1:0] exp_dat_i, exp_dat_o, exp_dir_o;
  logic [ `RP_LED_W-1:0] led_o;

  // reference model state
  logic                  m_loop;
  logic [ `RP_EXP_W-1:0] m_dir, m_out;
  logic [ `RP_LED_W-1:0] m_led;
  logic [1:0]            m_rta, m_rtb;
  logic [ `RP_SMP_W-1:0] m_ca, m_cb;

  int errors, checks, tests, cycle_cnt;

  rp_top dut0 (
    .adc_clk, .rst_i,
    .sys_addr_i, .sys_wdata_i, .sys_sel_i, .sys_wen_i, .sys_ren_i,
    .sys_rdata_o, .sys_err_o, .sys_ack_o,
    .adc_dat_a_i, .adc_dat_b_i, .dac_dat_a_o, .dac_dat_b_o,
    .exp_dat_i, .exp_dat_o, .exp_dir_o, .led_o
  );

  always #20 adc_clk = ~adc_clk;  // period 40

  ////////////////////
  // model rules
  // keep msb, invert the lower bits; same both ways
  function automatic logic [`RP_SMP_W-1:0] offset_flip(input logic [`RP_SMP_W-1:0] v);
    return v ^ {1'b0, {(`RP_SMP_W-1){1'b1}}};
  endfunction

  function automatic logic [`RP_SMP_W-1:0] route_src(input logic [1:0] r,
                                                     input logic [`RP_SMP_W-1:0] c, sa, sb);
    case (r)
      analog_pkg::ROUTE_ADC_A: return sa;
      analog_pkg::ROUTE_ADC_B: return sb;
      analog_pkg::ROUTE_CONST: return c;
      default:                 return '0;  // off
    endcase
  endfunction

  // register index to full bus address
  function automatic logic [31:0] reg_addr(input int idx);
    logic [19:0] offs;
    logic [2:0]  region;
    region = (idx < 6) ? 3'(bus_pkg::REG_HK) : 3'(bus_pkg::REG_ROUTER);
    case (idx)
      0:       offs = bus_pkg::ID;
      1:       offs = bus_pkg::LOOP;
      2:       offs = bus_pkg::EXP_DIR;
      3:       offs = bus_pkg::EXP_OUT;
      4:       offs = bus_pkg::EXP_IN;
      5:       offs = bus_pkg::LED;
      6:       offs = bus_pkg::ROUTE_A;
      7:       offs = bus_pkg::ROUTE_B;
      8:       offs = bus_pkg::CONST_A;
      default: offs = bus_pkg::CONST_B;
    endcase
    return {9'd0, region, offs};
  endfunction

  function automatic logic [31:0] model_read(input int idx);
    case (idx)
      0:       return `RP_HK_ID;
      1:       return 32'(m_loop);
      2:       return 32'(m_dir);
      3:       return 32'(m_out);
      4:       return 32'(exp_dat_i);  // live input
      5:       return 32'(m_led);
      6:       return 32'(m_rta);
      7:       return 32'(m_rtb);
      8:       return {{(32-`RP_SMP_W){m_ca[`RP_SMP_W-1]}}, m_ca};  // sign extended
      default: return {{(32-`RP_SMP_W){m_cb[`RP_SMP_W-1]}}, m_cb};
    endcase
  endfunction

  task automatic model_write(input int idx, input logic [31:0] d);
    case (idx)
      1:       m_loop = d[0];
      2:       m_dir  = d[`RP_EXP_W-1:0];
      3:       m_out  = d[`RP_EXP_W-1:0];
      5:       m_led  = d[`RP_LED_W-1:0];
      6:       m_rta  = d[1:0];
      7:       m_rtb  = d[1:0];
      8:       m_ca   = d[`RP_SMP_W-1:0];
      9:       m_cb   = d[`RP_SMP_W-1:0];
      default: ;  // ID, EXP_IN read only
    endcase
  endtask

  ////////////////////
  // checks and bus access
  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic strobe_and_wait(input logic wr, input logic [31:0] addr,
                                 input logic [31:0] data, input logic [3:0] sel,
                                 output logic [31:0] rdata, output logic err);
    int n;
    n = 0;
    sys_addr_i  = addr;  // held until the next access
    sys_wdata_i = data;
    sys_sel_i   = sel;
    sys_wen_i   = wr;
    sys_ren_i   = ~wr;
    @(posedge adc_clk);
    #2;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    while (!sys_ack_o && n < ACK_LIMIT)
    begin
      @(posedge adc_clk);
      #2;
      n++;
    end
    if (!sys_ack_o || n != 0)
    begin
      errors++;
      $display("bus access to %h not acknowledged one cycle after the strobe", addr);
    end
    rdata = sys_rdata_o;
    err   = sys_err_o;
    @(posedge adc_clk);
    #2;
    check_eq("sys_ack_o", sys_ack_o, 0);  // ack lasts one cycle
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] sel, output logic err);
    logic [31:0] unused;
    strobe_and_wait(1'b1, addr, data, sel, unused, err);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata, output logic err);
    strobe_and_wait(1'b0, addr, '0, 4'hF, rdata, err);
  endtask

  task automatic set_reg(input int idx, input logic [31:0] d);
    logic err;
    bus_write(reg_addr(idx), d, 4'hF, err);
    check_eq("sys_err_o", err, 0);
    model_write(idx, d);
  endtask

  task automatic check_pins();
    check_eq("led_o", led_o, m_led);
    check_eq("exp_dir_o", exp_dir_o, m_dir);
    check_eq("exp_dat_o", exp_dat_o, m_out);
  endtask

  // read every register back against the model
  task automatic verify_regs();
    logic [31:0] rd;
    logic        err;
    for (int idx = 0; idx < NREG; idx++)
    begin
      bus_read(reg_addr(idx), rd, err);
      check_eq($sformatf("sys_rdata_o reg %0d", idx), rd, model_read(idx));
      check_eq("sys_err_o", err, 0);
    end
  endtask

  // random ADC codes, DAC codes compared 3 cycles later
  task automatic run_stream(input int len);
    logic [`RP_SMP_W-1:0] code_a, code_b, smp_a, smp_b;
    logic [`RP_SMP_W-1:0] qa[$], qb[$];
    for (int i = 0; i < len; i++)
    begin
      if (qa.size() == 3)
      begin
        check_eq("dac_dat_a_o", dac_dat_a_o, qa.pop_front());
        check_eq("dac_dat_b_o", dac_dat_b_o, qb.pop_front());
      end
      code_a      = `RP_SMP_W'($urandom);
      code_b      = `RP_SMP_W'($urandom);
      adc_dat_a_i = code_a;
      adc_dat_b_i = code_b;
      smp_a       = offset_flip(code_a);  // code to sample
      smp_b       = offset_flip(code_b);
      qa.push_back(offset_flip(route_src(m_rta, m_ca, smp_a, smp_b)));  // and back
      qb.push_back(offset_flip(route_src(m_rtb, m_cb, smp_a, smp_b)));
      @(posedge adc_clk);
      #2;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("test %s: %s, %0d errors", name, (errors == err_before) ? "ok" : "bad",
             errors - err_before);
  endtask

  ////////////////////
  // run limit
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge adc_clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display(">>> FAIL");
    $finish;
  end

  ////////////////////
  // main sequence
  initial
  begin
    logic [31:0] rd, d, ua;
    logic        err;
    logic [3:0]  sel;
    int          idx, e0;
    void'($urandom(32'h45df));
    adc_clk     = 1'b0;
    rst_i       = 1'b1;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_sel_i   = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    exp_dat_i   = '0;
    {m_loop, m_dir, m_out, m_led, m_rta, m_rtb, m_ca, m_cb} = '0;
    errors = 0;
    checks = 0;
    tests  = 0;
    repeat (RST_CYCLES) @(posedge adc_clk);
    #2;
    rst_i = 1'b0;
    repeat (2) @(posedge adc_clk);
    #2;

    // 1: reset values
    e0 = errors;
    check_pins();
    check_eq("sys_ack_o", sys_ack_o, 0);
    check_eq("sys_err_o", sys_err_o, 0);
    check_eq("dac_dat_a_o", dac_dat_a_o, 14'h1FFF);  // sample 0
    check_eq("dac_dat_b_o", dac_dat_b_o, 14'h1FFF);
    report_test("reset values", e0);

    // 2: random register traffic
    e0 = errors;
    for (int i = 0; i < HK_ITER; i++)
    begin
      idx = $urandom_range(NREG - 1);
      d   = $urandom;
      sel = 4'($urandom);
      if ($urandom_range(3) != 0)
        sel[0] = 1'b1;                 // mostly lane 0 set
      exp_dat_i = `RP_EXP_W'($urandom);
      bus_write(reg_addr(idx), d, sel, err);
      check_eq("sys_err_o", err, 0);
      if (sel[0])
        model_write(idx, d);
      bus_read(reg_addr(idx), rd, err);
      check_eq($sformatf("sys_rdata_o reg %0d", idx), rd, model_read(idx));
      check_eq("sys_err_o", err, 0);
      // unused offset in region 0 or 1
      ua = {9'd0, 3'($urandom_range(1)), 20'h100 + 20'(4 * $urandom_range(63))};
      bus_write(ua, $urandom, 4'hF, err);
      check_eq("sys_err_o", err, 1);
      bus_read(ua, rd, err);
      check_eq("sys_err_o", err, 1);
      check_eq("sys_rdata_o", rd, 0);
      check_pins();
    end
    verify_regs();
    report_test("register access", e0);

    // 3: empty regions
    e0 = errors;
    for (int i = 0; i < UNM_ITER; i++)
    begin
      ua = reg_addr($urandom_range(NREG - 1));  // offset of a live register
      ua[`RP_REGION_MSB:`RP_REGION_LSB] = 3'($urandom_range(7, 2));
      if ($urandom_range(1) == 1)
      begin
        bus_write(ua, $urandom, 4'hF, err);
        check_eq("sys_err_o", err, 0);
      end
      else
      begin
        bus_read(ua, rd, err);
        check_eq("sys_rdata_o", rd, 0);
        check_eq("sys_err_o", err, 0);
      end
    end
    verify_regs();
    check_pins();
    report_test("unmapped regions", e0);

    // 4: crossed ADC to DAC stream
    e0 = errors;
    set_reg(1, 0);
    set_reg(6, 32'(analog_pkg::ROUTE_ADC_B));
    set_reg(7, 32'(analog_pkg::ROUTE_ADC_A));
    run_stream(STREAM_LEN);
    report_test("crossed stream", e0);

    // 5: constant through the loopback
    e0 = errors;
    set_reg(8, $urandom);
    set_reg(6, 32'(analog_pkg::ROUTE_CONST));
    set_reg(7, 32'(analog_pkg::ROUTE_ADC_A));
    set_reg(1, 1);
    for (int i = 0; i < SETTLE + STREAM_LEN / 2; i++)
    begin
      if (i >= SETTLE)
      begin
        check_eq("dac_dat_a_o", dac_dat_a_o, offset_flip(m_ca));
        check_eq("dac_dat_b_o", dac_dat_b_o, offset_flip(m_ca));  // via loop
      end
      adc_dat_a_i = `RP_SMP_W'($urandom);  // must not leak through
      adc_dat_b_i = `RP_SMP_W'($urandom);
      @(posedge adc_clk);
      #2;
    end
    set_reg(1, 0);                     // back to the ADC path
    run_stream(STREAM_LEN);
    report_test("loopback", e0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- hw/rp_top.sv
// fast analog path top, single adc_clk domain
// DAC data leaves as two parallel 14-bit buses, no DDR stage
// expansion port split into separate in, out and direction buses
`include "rp_defs.svh"

module rp_top (
  input  logic                  adc_clk,
  input  logic                  rst_i,
  // system bus
  input  logic [`RP_ADDR_W-1:0] sys_addr_i,
  input  logic [`RP_DATA_W-1:0] sys_wdata_i,
  input  logic [ `RP_SEL_W-1:0] sys_sel_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output logic [`RP_DATA_W-1:0] sys_rdata_o,
  output logic                  sys_err_o,
  output logic                  sys_ack_o,
  // converters
  input  analog_pkg::raw_t      adc_dat_a_i,
  input  analog_pkg::raw_t      adc_dat_b_i,
  output analog_pkg::raw_t      dac_dat_a_o,
  output analog_pkg::raw_t      dac_dat_b_o,
  // board io
  input  logic [ `RP_EXP_W-1:0] exp_dat_i,
  output logic [ `RP_EXP_W-1:0] exp_dat_o,
  output logic [ `RP_EXP_W-1:0] exp_dir_o,  // 1 = drive
  output logic [ `RP_LED_W-1:0] led_o
);

  analog_pkg::sample_t adc_a, adc_b;  // toward router
  analog_pkg::sample_t dac_a, dac_b;  // from router
  logic                digital_loop;

  sys_bus_if hk_bus ();  // region 0
  sys_bus_if rt_bus ();  // region 1

  sys_bus_decoder i_dec (
    .adc_clk, .rst_i,
    .sys_addr_i, .sys_wdata_i, .sys_sel_i, .sys_wen_i, .sys_ren_i,
    .sys_rdata_o, .sys_err_o, .sys_ack_o,
    .hk_bus (hk_bus), .rt_bus (rt_bus)
  );

  housekeeping_regs i_hk (
    .adc_clk, .rst_i, .bus (hk_bus),
    .exp_dat_i, .exp_dat_o, .exp_dir_o, .led_o,
    .digital_loop_o (digital_loop)
  );

  analog_io i_aio (
    .adc_clk, .rst_i, .adc_dat_a_i, .adc_dat_b_i,
    .digital_loop_i (digital_loop),
    .dac_a_i (dac_a), .dac_b_i (dac_b),
    .adc_a_o (adc_a), .adc_b_o (adc_b),
    .dac_dat_a_o, .dac_dat_b_o
  );

  output_router i_rt (
    .adc_clk, .rst_i, .bus (rt_bus),
    .adc_a_i (adc_a), .adc_b_i (adc_b),
    .dac_a_o (dac_a), .dac_b_o (dac_b)
  );

endmodule

//--- hw/output_router.sv
// region 1: per-channel source select toward the DAC
// route field is wdata[1:0], constants are 14-bit signed
// output registered, one cycle from source or register change
`include "rp_defs.svh"

module output_router (
  input  logic                 adc_clk,
  input  logic                 rst_i,
  sys_bus_if.slave             bus,
  input  analog_pkg::sample_t  adc_a_i,
  input  analog_pkg::sample_t  adc_b_i,
  output analog_pkg::sample_t  dac_a_o,
  output analog_pkg::sample_t  dac_b_o
);

  analog_pkg::route_e  route_a, route_b;
  analog_pkg::sample_t const_a, const_b;

  // pick one source for a channel
  function automatic analog_pkg::sample_t pick(input analog_pkg::route_e  r,
                                               input analog_pkg::sample_t c,
                                               input analog_pkg::sample_t a,
                                               input analog_pkg::sample_t b);
    case (r)
      analog_pkg::ROUTE_ADC_A: return a;
      analog_pkg::ROUTE_ADC_B: return b;
      analog_pkg::ROUTE_CONST: return c;
      default:                 return '0;  // off
    endcase
  endfunction

  ////////////////////
  // register file
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      route_a   <= analog_pkg::ROUTE_OFF;
      route_b   <= analog_pkg::ROUTE_OFF;
      const_a   <= '0;
      const_b   <= '0;
      bus.ack   <= 1'b0;
      bus.err   <= 1'b0;
      bus.rdata <= '0;
    end
    else
    begin
      bus.ack <= bus.wen | bus.ren;
      bus.err <= 1'b0;
      if (bus.wen && bus.sel[0])
      begin
        case (bus.addr)
          bus_pkg::ROUTE_A: route_a <= analog_pkg::route_e'(bus.wdata[1:0]);
          bus_pkg::ROUTE_B: route_b <= analog_pkg::route_e'(bus.wdata[1:0]);
          bus_pkg::CONST_A: const_a <= bus.wdata[`RP_SMP_W-1:0];
          bus_pkg::CONST_B: const_b <= bus.wdata[`RP_SMP_W-1:0];
          default: ;
        endcase
      end
      if (bus.wen | bus.ren)
      begin
        case (bus.addr)
          bus_pkg::ROUTE_A: bus.rdata <= {{(`RP_DATA_W-2){1'b0}}, route_a};
          bus_pkg::ROUTE_B: bus.rdata <= {{(`RP_DATA_W-2){1'b0}}, route_b};
          bus_pkg::CONST_A: bus.rdata <= {{(`RP_DATA_W-`RP_SMP_W){const_a[`RP_SMP_W-1]}}, const_a};
          bus_pkg::CONST_B: bus.rdata <= {{(`RP_DATA_W-`RP_SMP_W){const_b[`RP_SMP_W-1]}}, const_b};
          default:
          begin
            bus.rdata <= '0;
            bus.err   <= 1'b1;  // unused offset
          end
        endcase
      end
    end
  end

  ////////////////////
  // sample path, runs every cycle
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_a_o <= '0;
      dac_b_o <= '0;
    end
    else
    begin
      dac_a_o <= pick(route_a, const_a, adc_a_i, adc_b_i);
      dac_b_o <= pick(route_b, const_b, adc_a_i, adc_b_i);
    end
  end

endmodule

//--- hw/analog_io.sv
// ADC capture and DAC output registers with code conversion
// converter codes are negative-slope offset binary, samples signed
// loopback replaces the ADC samples combinationally with DAC samples
`include "rp_defs.svh"

module analog_io (
  input  logic                 adc_clk,
  input  logic                 rst_i,
  input  analog_pkg::raw_t     adc_dat_a_i,
  input  analog_pkg::raw_t     adc_dat_b_i,
  input  logic                 digital_loop_i,
  input  analog_pkg::sample_t  dac_a_i,
  input  analog_pkg::sample_t  dac_b_i,
  output analog_pkg::sample_t  adc_a_o,
  output analog_pkg::sample_t  adc_b_o,
  output analog_pkg::raw_t     dac_dat_a_o,
  output analog_pkg::raw_t     dac_dat_b_o
);

  analog_pkg::raw_t adc_dat_a;  // input register, ch a
  analog_pkg::raw_t adc_dat_b;  // input register, ch b

  ////////////////////
  // ADC side
  always_ff @(posedge adc_clk)
  begin
    adc_dat_a <= adc_dat_a_i;  // sampled every cycle
    adc_dat_b <= adc_dat_b_i;
  end

  // code to sample, or loop the DAC path back in
  assign adc_a_o = digital_loop_i ? dac_a_i
                                  : analog_pkg::sample_t'(analog_pkg::nsob_flip(adc_dat_a));
  assign adc_b_o = digital_loop_i ? dac_b_i
                                  : analog_pkg::sample_t'(analog_pkg::nsob_flip(adc_dat_b));

  ////////////////////
  // DAC side
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_dat_a_o <= {1'b0, {(`RP_SMP_W-1){1'b1}}};  // mid-scale, sample 0
      dac_dat_b_o <= {1'b0, {(`RP_SMP_W-1){1'b1}}};
    end
    else
    begin
      dac_dat_a_o <= analog_pkg::raw_t'(analog_pkg::nsob_flip(dac_a_i));
      dac_dat_b_o <= analog_pkg::raw_t'(analog_pkg::nsob_flip(dac_b_i));
    end
  end

endmodule

//--- hw/housekeeping_regs.sv
// region 0: id, digital loopback, expansion port and leds
// writes need sel[0]; ID and EXP_IN ignore writes
// unknown offsets ack with err set and rdata 0
`include "rp_defs.svh"

module housekeeping_regs (
  input  logic                 adc_clk,
  input  logic                 rst_i,
  sys_bus_if.slave             bus,
  input  logic [`RP_EXP_W-1:0] exp_dat_i,
  output logic [`RP_EXP_W-1:0] exp_dat_o,
  output logic [`RP_EXP_W-1:0] exp_dir_o,
  output logic [`RP_LED_W-1:0] led_o,
  output logic                 digital_loop_o
);

  logic strobe;  // any access this cycle

  assign strobe = bus.wen | bus.ren;

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      digital_loop_o <= 1'b0;
      exp_dir_o      <= '0;  // all inputs after reset
      exp_dat_o      <= '0;
      led_o          <= '0;
      bus.ack        <= 1'b0;
      bus.err        <= 1'b0;
      bus.rdata      <= '0;
    end
    else
    begin
      bus.ack <= strobe;  // single-cycle answer
      bus.err <= 1'b0;

      ////////////////////
      // write, lane 0 only
      if (bus.wen && bus.sel[0])
      begin
        case (bus.addr)
          bus_pkg::LOOP:    digital_loop_o <= bus.wdata[0];
          bus_pkg::EXP_DIR: exp_dir_o      <= bus.wdata[`RP_EXP_W-1:0];
          bus_pkg::EXP_OUT: exp_dat_o      <= bus.wdata[`RP_EXP_W-1:0];
          bus_pkg::LED:     led_o          <= bus.wdata[`RP_LED_W-1:0];
          default: ;  // read only or unused
        endcase
      end

      ////////////////////
      // read back, also on writes
      if (strobe)
      begin
        case (bus.addr)
          bus_pkg::ID:      bus.rdata <= `RP_HK_ID;
          bus_pkg::LOOP:    bus.rdata <= {{(`RP_DATA_W-1){1'b0}}, digital_loop_o};
          bus_pkg::EXP_DIR: bus.rdata <= {{(`RP_DATA_W-`RP_EXP_W){1'b0}}, exp_dir_o};
          bus_pkg::EXP_OUT: bus.rdata <= {{(`RP_DATA_W-`RP_EXP_W){1'b0}}, exp_dat_o};
          bus_pkg::EXP_IN:  bus.rdata <= {{(`RP_DATA_W-`RP_EXP_W){1'b0}}, exp_dat_i};
          bus_pkg::LED:     bus.rdata <= {{(`RP_DATA_W-`RP_LED_W){1'b0}}, led_o};
          default:
          begin
            bus.rdata <= '0;
            bus.err   <= 1'b1;  // no register here
          end
        endcase
      end
    end
  end

endmodule

//--- hw/sys_bus_decoder.sv
// splits the system bus into eight 1 MiB regions on addr[22:20]
// only regions 0 and 1 have slaves; the rest ack with zero data
// one outstanding access, address held until ack
`include "rp_defs.svh"

module sys_bus_decoder (
  input  logic                  adc_clk,
  input  logic                  rst_i,
  input  logic [`RP_ADDR_W-1:0] sys_addr_i,
  input  logic [`RP_DATA_W-1:0] sys_wdata_i,
  input  logic [ `RP_SEL_W-1:0] sys_sel_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output logic [`RP_DATA_W-1:0] sys_rdata_o,
  output logic                  sys_err_o,
  output logic                  sys_ack_o,
  sys_bus_if.master             hk_bus,
  sys_bus_if.master             rt_bus
);

  bus_pkg::region_e region;
  logic             mapped;   // region has a slave
  logic             unm_ack;  // ack for unmapped regions

  assign region = bus_pkg::region_e'(sys_addr_i[`RP_REGION_MSB:`RP_REGION_LSB]);
  assign mapped = (region == bus_pkg::REG_HK) || (region == bus_pkg::REG_ROUTER);

  ////////////////////
  // request side, offset and data shared
  assign hk_bus.addr  = sys_addr_i[`RP_OFFS_W-1:0];
  assign hk_bus.wdata = sys_wdata_i;
  assign hk_bus.sel   = sys_sel_i;
  assign hk_bus.wen   = sys_wen_i & (region == bus_pkg::REG_HK);  // gated strobes
  assign hk_bus.ren   = sys_ren_i & (region == bus_pkg::REG_HK);

  assign rt_bus.addr  = sys_addr_i[`RP_OFFS_W-1:0];
  assign rt_bus.wdata = sys_wdata_i;
  assign rt_bus.sel   = sys_sel_i;
  assign rt_bus.wen   = sys_wen_i & (region == bus_pkg::REG_ROUTER);
  assign rt_bus.ren   = sys_ren_i & (region == bus_pkg::REG_ROUTER);

  // empty regions answer one cycle after the strobe
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      unm_ack <= 1'b0;
    else
      unm_ack <= (sys_wen_i | sys_ren_i) & ~mapped;
  end

  ////////////////////
  // response mux, address still stable here
  always_comb
  begin
    case (region)
      bus_pkg::REG_HK:
      begin
        sys_rdata_o = hk_bus.rdata;
        sys_err_o   = hk_bus.err;
        sys_ack_o   = hk_bus.ack;
      end
      bus_pkg::REG_ROUTER:
      begin
        sys_rdata_o = rt_bus.rdata;
        sys_err_o   = rt_bus.err;
        sys_ack_o   = rt_bus.ack;
      end
      default:
      begin
        sys_rdata_o = '0;       // nothing behind it
        sys_err_o   = 1'b0;
        sys_ack_o   = unm_ack;
      end
    endcase
  end

endmodule

//--- hw/sys_bus_if.sv
// strobe / acknowledge register bus, one region wide
// master holds addr, wdata, sel and pulses wen or ren one cycle
// slave answers with a one-cycle ack, rdata and err valid with it
`include "rp_defs.svh"

interface sys_bus_if;

  logic [ `RP_OFFS_W-1:0] addr;   // in-region offset only
  logic [ `RP_DATA_W-1:0] wdata;
  logic [  `RP_SEL_W-1:0] sel;    // byte selects
  logic                   wen;    // write strobe
  logic                   ren;    // read strobe
  logic [ `RP_DATA_W-1:0] rdata;
  logic                   err;
  logic                   ack;

  // decoder side
  modport master (output addr, wdata, sel, wen, ren,
                  input  rdata, err, ack);

  // register block side
  modport slave  (input  addr, wdata, sel, wen, ren,
                  output rdata, err, ack);

endinterface

//--- hw/analog_pkg.sv
// analog side types and the converter code mapping
// converters use negative-slope offset binary
`include "rp_defs.svh"

package analog_pkg;

  typedef logic signed [`RP_SMP_W-1:0] sample_t;  // two's complement
  typedef logic        [`RP_SMP_W-1:0] raw_t;     // converter code

  // per-channel source select
  typedef enum logic [1:0] {
    ROUTE_OFF   = 2'd0,  // drive zero
    ROUTE_ADC_A = 2'd1,
    ROUTE_ADC_B = 2'd2,
    ROUTE_CONST = 2'd3   // channel constant
  } route_e;

  // same bit operation both ways: keep msb, invert the rest
  function automatic logic [`RP_SMP_W-1:0] nsob_flip(input logic [`RP_SMP_W-1:0] v);
    return {v[`RP_SMP_W-1], ~v[`RP_SMP_W-2:0]};
  endfunction

endpackage

//--- hw/bus_pkg.sv
// bus side types: region names and register offsets
// offsets are byte addresses relative to the region base
`include "rp_defs.svh"

package bus_pkg;

  // regions, picked by addr[22:20]
  typedef enum logic [`RP_REGION_MSB-`RP_REGION_LSB:0] {
    REG_HK     = 'd0,  // housekeeping
    REG_ROUTER = 'd1,  // output router
    REG_FREE2  = 'd2,  // unmapped from here on
    REG_FREE3  = 'd3,
    REG_FREE4  = 'd4,
    REG_FREE5  = 'd5,
    REG_FREE6  = 'd6,
    REG_FREE7  = 'd7
  } region_e;

  // housekeeping offsets
  typedef enum logic [`RP_OFFS_W-1:0] {
    ID      = 'h00,  // read only
    LOOP    = 'h04,  // digital loopback flag
    EXP_DIR = 'h10,  // 1 = output
    EXP_OUT = 'h14,
    EXP_IN  = 'h18,  // read only
    LED     = 'h30
  } hk_offs_e;

  // router offsets
  typedef enum logic [`RP_OFFS_W-1:0] {
    ROUTE_A = 'h00,
    ROUTE_B = 'h04,
    CONST_A = 'h08,
    CONST_B = 'h0C
  } rt_offs_e;

endpackage

//--- hw/rp_defs.svh
// shared widths and constants for the fast analog path
// every access is 32 bit; all registers live in byte lane 0
// region field is addr[22:20], so each region spans 1 MiB
`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

////////////////////
// system bus
`define RP_DATA_W      32        // bus data width
`define RP_ADDR_W      32        // bus address width
`define RP_SEL_W       4         // byte selects
`define RP_REGION_LSB  20        // region field, low bit
`define RP_REGION_MSB  22        // region field, high bit
`define RP_N_REGIONS   8
`define RP_OFFS_W      20        // offset inside one region

////////////////////
// analog path and board io
`define RP_SMP_W       14        // converter resolution
`define RP_EXP_W       8         // expansion port
`define RP_LED_W       8

// fixed id read back from housekeeping offset 0
`define RP_HK_ID       32'h5250_0100

`endif
